// ==== list.f ====
source/cheat_pkg.sv
source/prog_descrambler.sv
source/prog_load_fsm.sv
source/load_counter.sv
source/byte_packer.sv
source/prog_ram.sv
source/cheat_rom_top.sv
verif/cheat_rom_properties.sv
verif/cheat_rom_checker.sv
verif/cheat_rom_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cheat_rom_tb \
    -f list.f -o cheat_rom_sim > sim.log 2>&1 \
    && ./obj_dir/cheat_rom_sim >> sim.log 2>&1 \
    || echo "Build or simulation stopped with an error" >> sim.log
grep -qx "Verification passed" sim.log && echo "PASS, see sim.log" && exit 0 \
    || { echo "FAIL, see sim.log"; exit 1; }

// ==== source/byte_packer.sv ====
// Expects the phase to follow 0..8 in order; a skipped phase corrupts the group
`default_nettype none

module byte_packer import cheat_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       restart,
    input  logic       take,
    input  prog_byte_t in_byte,
    output word_wr_t   wr
);

    // Holds the two most recent bytes, newest in the top half
    logic [15:0] sreg;
    logic        completes;
    word_t       next_word;
    logic        we_q;
    word_t       word_q;

    // Every even phase past zero closes a word
    // The number of low bits taken from the new byte grows by two each time
    always_comb begin
        completes = 1'b1;
        case (in_byte.phase)
            4'd2: next_word = {in_byte.data[1:0], sreg};
            4'd4: next_word = {in_byte.data[3:0], sreg[15:2]};
            4'd6: next_word = {in_byte.data[5:0], sreg[15:4]};
            4'd8: next_word = {in_byte.data, sreg[15:6]};
            default: begin
                // Odd phases and phase 0 only feed the register
                completes = 1'b0;
                next_word = '0;
            end
        endcase
    end

    // Write strobe is control state, so it has the reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we_q <= 1'b0;
        end else if (restart) begin
            // A pending write from the old load must not land
            we_q <= 1'b0;
        end else begin
            we_q <= take & completes;
        end
    end

    always_ff @(posedge clk) begin
        if (restart) begin
            sreg <= '0;
        end else if (take) begin
            // New byte enters at the top, the oldest drops off the bottom
            sreg <= {in_byte.data, sreg[15:8]};
        end
        // The word only changes when a byte closes it
        if (take && completes) begin
            word_q <= next_word;
        end
    end

    assign wr = '{we: we_q, data: word_q};

endmodule

`default_nettype wire

// ==== source/cheat_pkg.sv ====
// Shared types for the program loader; words are fixed at 18 bits and a group is 9 bytes
`default_nettype none

package cheat_pkg;

    // One processor instruction word as stored in program memory
    typedef logic [17:0] word_t;

    // Nine bytes of host data pack into four instruction words
    localparam int BYTES_PER_GROUP = 9;
    localparam int WORDS_PER_GROUP = 4;

    // A byte accepted from the host, already descrambled
    // Phase is its position inside the current nine-byte group
    typedef struct packed {
        logic [7:0] data;
        logic [3:0] phase;
    } prog_byte_t;

    // Write request towards the program memory
    // The address is carried on its own bus since its width is a parameter
    typedef struct packed {
        logic  we;
        word_t data;
    } word_wr_t;

    // Loader states
    // FULL is held until the host opens a new load
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        LOAD = 2'd1,
        FULL = 2'd2
    } load_state_t;

endpackage

`default_nettype wire

// ==== source/cheat_rom_top.sv ====
// No back-pressure; the host strobes at most one byte per cycle and only after the restart cycle
`default_nettype none

module cheat_rom_top import cheat_pkg::*; #(
    parameter int          AW           = 10,
    parameter bit          SCRAMBLE_EN  = 1'b0,
    parameter logic [15:0] SCRAMBLE_KEY = 16'h0000
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          prog_en,
    input  logic          prog_wr,
    input  logic [7:0]    prog_data,
    input  logic [AW-1:0] iaddr,
    output word_t         idata,
    output logic          prog_full
);

    logic          restart;
    logic          take;
    logic          at_last;
    logic [3:0]    phase;
    logic [7:0]    byte_idx;
    logic [AW-1:0] word_addr;
    logic [7:0]    clean_byte;
    prog_byte_t    in_byte;
    word_wr_t      wr;

    // Loader control
    prog_load_fsm u_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_en   (prog_en),
        .prog_wr   (prog_wr),
        .at_last   (at_last),
        .word_we   (wr.we),
        .restart   (restart),
        .take      (take),
        .prog_full (prog_full)
    );

    load_counter #(.AW(AW)) u_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .restart   (restart),
        .take      (take),
        .word_we   (wr.we),
        .phase     (phase),
        .byte_idx  (byte_idx),
        .word_addr (word_addr),
        .at_last   (at_last)
    );

    prog_descrambler #(
        .SCRAMBLE_EN  (SCRAMBLE_EN),
        .SCRAMBLE_KEY (SCRAMBLE_KEY)
    ) u_descrambler (
        .raw      (prog_data),
        .byte_idx (byte_idx),
        .clean    (clean_byte)
    );

    // The packer needs the byte and where it sits in its group
    assign in_byte = '{data: clean_byte, phase: phase};

    byte_packer u_packer (
        .clk     (clk),
        .rst_n   (rst_n),
        .restart (restart),
        .take    (take),
        .in_byte (in_byte),
        .wr      (wr)
    );

    prog_ram #(.AW(AW)) u_ram (
        .clk     (clk),
        .wr      (wr),
        .wr_addr (word_addr),
        .rd_addr (iaddr),
        .q       (idata)
    );

endmodule

`default_nettype wire

// ==== source/load_counter.sv ====
// Byte index wraps at 256 and the word address wraps after the last word; restart clears both
`default_nettype none

module load_counter import cheat_pkg::*; #(
    parameter int AW = 10
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          restart,
    input  logic          take,
    input  logic          word_we,
    output logic [3:0]    phase,
    output logic [7:0]    byte_idx,
    output logic [AW-1:0] word_addr,
    output logic          at_last
);

    localparam logic [3:0] LAST_PHASE = 4'(BYTES_PER_GROUP - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= 4'd0;
            byte_idx  <= 8'd0;
            word_addr <= '0;
        end else if (restart) begin
            phase     <= 4'd0;
            byte_idx  <= 8'd0;
            word_addr <= '0;
        end else begin
            if (take) begin
                // Phase walks 0..8 and then opens the next group
                phase    <= (phase == LAST_PHASE) ? 4'd0 : phase + 4'd1;
                // The descramble seed simply wraps
                byte_idx <= byte_idx + 8'd1;
            end
            // The address moves once the write has been done,
            // so the packer never has to know it
            if (word_we) begin
                word_addr <= word_addr + 1'b1;
            end
        end
    end

    assign at_last = (word_addr == {AW{1'b1}});

endmodule

`default_nettype wire

// ==== source/prog_descrambler.sv ====
// Purely combinational; the byte index must count accepted bytes from 0 after each restart
`default_nettype none

module prog_descrambler #(
    parameter bit          SCRAMBLE_EN  = 1'b0,
    parameter logic [15:0] SCRAMBLE_KEY = 16'h0000
) (
    input  logic [7:0] raw,
    input  logic [7:0] byte_idx,
    output logic [7:0] clean
);

    // Swap the two bits of every pair whose select bit is set
    // Select bit 0 covers bits 1:0, select bit 3 covers bits 7:6
    function automatic logic [7:0] swap_pairs(input logic [7:0] din, input logic [3:0] sel);
        logic [7:0] dout;
        dout = din;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                dout[2*i]   = din[2*i+1];
                dout[2*i+1] = din[2*i];
            end
        end
        return dout;
    endfunction

    logic [7:0] mask;
    logic [7:0] stage1;
    logic [7:0] stage2;

    always_comb begin
        // The low key byte seeds the swap mask, so every byte index
        // sees a different permutation
        mask   = byte_idx ^ SCRAMBLE_KEY[7:0];
        // First swap pass uses the low half of the mask
        stage1 = swap_pairs(raw, mask[3:0]);
        // The high key byte is a plain XOR between the two passes
        stage2 = stage1 ^ SCRAMBLE_KEY[15:8];
        if (SCRAMBLE_EN) begin
            // Second pass uses the high half of the mask
            clean = swap_pairs(stage2, mask[7:4]);
        end else begin
            // Unscrambled builds take the host byte as it is
            clean = raw;
        end
    end

endmodule

`default_nettype wire

// ==== source/prog_load_fsm.sv ====
// Host must hold prog_en high for the whole load; a fall drops the load, prog_full holds until restart
`default_nettype none

module prog_load_fsm import cheat_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic prog_en,
    input  logic prog_wr,
    input  logic at_last,
    input  logic word_we,
    output logic restart,
    output logic take,
    output logic prog_full
);

    load_state_t state;
    load_state_t state_nxt;
    logic        prog_en_q;

    // Edge detector for prog_en
    // restart is registered, so it appears the cycle after the rising edge
    // and any strobe on that cycle is not yet taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_en_q <= 1'b0;
            restart   <= 1'b0;
        end else begin
            prog_en_q <= prog_en;
            restart   <= prog_en & ~prog_en_q;
        end
    end

    always_comb begin
        state_nxt = state;
        if (restart) begin
            // A restart wins over everything, even a FULL memory
            // If the host already let go of prog_en, stay idle
            state_nxt = prog_en ? LOAD : IDLE;
        end else begin
            case (state)
                LOAD: begin
                    if (!prog_en) begin
                        // Load abandoned, the partial group is lost
                        state_nxt = IDLE;
                    end else if (word_we && at_last) begin
                        // The last memory word is being written now
                        state_nxt = FULL;
                    end
                end
                FULL: begin
                    // Only a restart leaves FULL
                    state_nxt = FULL;
                end
                default: begin
                    state_nxt = IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Byte strobes are only honoured while loading
    assign take      = prog_wr & prog_en & (state == LOAD);
    assign prog_full = (state == FULL);

endmodule

`default_nettype wire

// ==== source/prog_ram.sv ====
// Contents are undefined until written; a same-address read and write returns the old word
`default_nettype none

module prog_ram import cheat_pkg::*; #(
    parameter int AW = 10
) (
    input  logic          clk,
    input  word_wr_t      wr,
    input  logic [AW-1:0] wr_addr,
    input  logic [AW-1:0] rd_addr,
    output word_t         q
);

    localparam int DEPTH = 2 ** AW;

    word_t mem [DEPTH];

    // Write port, driven by the loader
    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr_addr] <= wr.data;
        end
    end

    // Read port for the processor
    // One clock of latency, the output is a plain register
    always_ff @(posedge clk) begin
        q <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== verif/cheat_rom_checker.sv ====
// Reference model assumes descrambling is on; words never written are not checked
`default_nettype none

module cheat_rom_checker import cheat_pkg::*; #(
    parameter int          AW           = 4,
    parameter logic [15:0] SCRAMBLE_KEY = 16'h0000
) (
    input logic          clk,
    input logic          rst_n,
    input logic          prog_en,
    input logic          prog_wr,
    input logic [7:0]    prog_data,
    input logic [AW-1:0] iaddr,
    input word_t         idata,
    input logic          prog_full
);

    localparam int DEPTH = 2 ** AW;

    // Written by the testbench so that error lines carry the test name
    string cur_test    = "reset";
    int    err_count   = 0;
    int    check_count = 0;

    // Model memory, a word only counts once the model has written it
    word_t       mem_m [DEPTH];
    bit          valid_m [DEPTH];
    logic [71:0] group_m;
    int          phase_m;
    logic [7:0]  idx_m;
    logic [AW-1:0] addr_m;
    bit          en_q;
    bit          restart_m;
    bit          pend_we;
    word_t       pend_word;
    load_state_t state_m = IDLE;
    word_t       exp_idata;
    bit          exp_valid;

    // Swaps the selected bit pairs by masking a fully swapped copy
    function automatic logic [7:0] swap_selected(input logic [7:0] x, input logic [3:0] sel);
        logic [7:0] pair_mask;
        logic [7:0] swapped;
        pair_mask = {{2{sel[3]}}, {2{sel[2]}}, {2{sel[1]}}, {2{sel[0]}}};
        swapped   = {x[6], x[7], x[4], x[5], x[2], x[3], x[0], x[1]};
        return (swapped & pair_mask) | (x & ~pair_mask);
    endfunction

    function automatic logic [7:0] descramble(input logic [7:0] raw, input logic [7:0] idx);
        logic [7:0] mask;
        logic [7:0] mid;
        mask = idx ^ SCRAMBLE_KEY[7:0];
        mid  = swap_selected(raw, mask[3:0]) ^ SCRAMBLE_KEY[15:8];
        return swap_selected(mid, mask[7:4]);
    endfunction

    // Model step, driven by input values that were settled before the edge
    always @(posedge clk or negedge rst_n) begin
        bit take_m;
        int bits_before;
        int bits_after;
        if (!rst_n) begin
            en_q      = 1'b0;
            restart_m = 1'b0;
            state_m   = IDLE;
            phase_m   = 0;
            idx_m     = 8'd0;
            addr_m    = '0;
            pend_we   = 1'b0;
            exp_valid = 1'b0;
        end else begin
            take_m = prog_wr && prog_en && (state_m == LOAD);
            // The read port still sees the word from before this edge's write
            exp_valid = valid_m[iaddr];
            exp_idata = mem_m[iaddr];
            if (pend_we) begin
                mem_m[addr_m]   = pend_word;
                valid_m[addr_m] = 1'b1;
            end
            if (restart_m) begin
                state_m = prog_en ? LOAD : IDLE;
            end else if (state_m == LOAD && !prog_en) begin
                state_m = IDLE;
            end else if (state_m == LOAD && pend_we && addr_m == {AW{1'b1}}) begin
                state_m = FULL;
            end
            if (restart_m) begin
                phase_m = 0;
                idx_m   = 8'd0;
                addr_m  = '0;
                pend_we = 1'b0;
            end else begin
                if (pend_we) begin
                    addr_m = addr_m + {{(AW-1){1'b0}}, 1'b1};
                end
                pend_we = 1'b0;
                if (take_m) begin
                    group_m[8*phase_m +: 8] = descramble(prog_data, idx_m);
                    // A word is done when the group's bit count crosses a multiple of 18
                    bits_before = 8 * phase_m;
                    bits_after  = 8 * (phase_m + 1);
                    if (bits_after / 18 > bits_before / 18 &&
                        bits_before / 18 < WORDS_PER_GROUP) begin
                        pend_word = group_m[18*(bits_before/18) +: 18];
                        pend_we   = 1'b1;
                    end
                    phase_m = (phase_m + 1) % BYTES_PER_GROUP;
                    idx_m   = idx_m + 8'd1;
                end
            end
            restart_m = prog_en && !en_q;
            en_q      = prog_en;
        end
    end

    // Outputs are compared half a cycle after the edge that produced them
    always @(negedge clk) begin
        if (rst_n) begin
            if (exp_valid) begin
                check_count++;
                if (idata !== exp_idata) begin
                    err_count++;
                    $display("FAIL %s idata expected %05h actual %05h",
                             cur_test, exp_idata, idata);
                end
            end
            check_count++;
            if (prog_full !== (state_m == FULL)) begin
                err_count++;
                $display("FAIL %s prog_full expected %0b actual %0b",
                         cur_test, (state_m == FULL), prog_full);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/cheat_rom_properties.sv ====
// Bound into every prog_load_fsm instance; checks hold only while rst_n is high
`default_nettype none

module cheat_rom_properties import cheat_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input load_state_t state,
    input logic        take,
    input logic        restart,
    input logic        word_we,
    input logic        at_last,
    input logic        prog_full
);

    // A byte is only taken inside an open load
    // LOAD is entered through a restart, so the restart cycle itself never takes a byte
    take_only_in_load: assert property (@(posedge clk) disable iff (!rst_n)
        take |-> ($past(state) == LOAD) || $past(restart))
        else $error("take was raised before a restart had opened the load");

    // A restart reopens the memory whatever the previous load left behind
    restart_clears_full: assert property (@(posedge clk) disable iff (!rst_n)
        restart |=> !prog_full)
        else $error("prog_full was still high in the cycle after a restart");

    // The full flag rises only on the cycle after the last word was written
    full_after_last_write: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(prog_full) |-> $past(word_we && at_last))
        else $error("prog_full rose without a write to the last address");

endmodule

bind prog_load_fsm cheat_rom_properties u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .state     (state),
    .take      (take),
    .restart   (restart),
    .word_we   (word_we),
    .at_last   (at_last),
    .prog_full (prog_full)
);

`default_nettype wire

// ==== verif/cheat_rom_tb.sv ====
// Runs a 16-word build with the key 16'h5a3c; every read is checked by the checker instance
`default_nettype none

module cheat_rom_tb import cheat_pkg::*; ();

    localparam int          AW           = 4;
    localparam int          DEPTH        = 2 ** AW;
    localparam logic [15:0] SCRAMBLE_KEY = 16'h5a3c;
    localparam int          NUM_TESTS    = 6;

    typedef enum int {MODE_NORMAL, MODE_RESTART, MODE_NO_EN} mode_t;

    // Stimulus table with the expected state of prog_full after each row
    string test_names [NUM_TESTS] = '{"full_group", "partial_five", "strobe_no_en",
                                      "restart_mid", "fill_memory", "after_full"};
    int    byte_counts [NUM_TESTS] = '{9, 5, 9, 18, 40, 9};
    mode_t test_modes [NUM_TESTS]  = '{MODE_NORMAL, MODE_NORMAL, MODE_NO_EN,
                                       MODE_RESTART, MODE_NORMAL, MODE_NORMAL};
    bit    exp_full [NUM_TESTS]    = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};

    logic          clk;
    logic          rst_n;
    logic          prog_en;
    logic          prog_wr;
    logic [7:0]    prog_data;
    logic [AW-1:0] iaddr;
    word_t         idata;
    logic          prog_full;
    int            tb_errors;

    cheat_rom_top #(.AW(AW), .SCRAMBLE_EN(1'b1), .SCRAMBLE_KEY(SCRAMBLE_KEY)) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_en   (prog_en),
        .prog_wr   (prog_wr),
        .prog_data (prog_data),
        .iaddr     (iaddr),
        .idata     (idata),
        .prog_full (prog_full)
    );

    cheat_rom_checker #(.AW(AW), .SCRAMBLE_KEY(SCRAMBLE_KEY)) chk (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Inputs change 10 units after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    // One strobe, a random read address, and now and then an idle cycle
    task automatic send_byte(input logic [7:0] value);
        prog_wr   = 1'b1;
        prog_data = value;
        iaddr     = AW'($urandom);
        next_cycle();
        prog_wr = 1'b0;
        if ($urandom_range(0, 3) == 0) begin
            next_cycle();
        end
    endtask

    task automatic stream_bytes(input int count);
        for (int n = 0; n < count; n++) begin
            send_byte(8'($urandom));
        end
    endtask

    // Edge detect and the restart cycle pass before bytes are taken
    task automatic open_load();
        prog_en = 1'b1;
        next_cycle();
        next_cycle();
    endtask

    // Two cycles let the write of a just completed word land
    task automatic close_load();
        prog_en = 1'b0;
        next_cycle();
        next_cycle();
    endtask

    task automatic read_back();
        for (int a = 0; a < DEPTH; a++) begin
            iaddr = AW'(a);
            next_cycle();
        end
        next_cycle();
    endtask

    task automatic run_test(input int i);
        int err_start;
        err_start     = chk.err_count + tb_errors;
        chk.cur_test  = test_names[i];
        case (test_modes[i])
            MODE_NO_EN: begin
                // Two bytes open a group, so the first strobe with prog_en low
                // still meets the LOAD state and would close word 0 if taken
                open_load();
                stream_bytes(2);
                prog_en = 1'b0;
                stream_bytes(byte_counts[i]);
                next_cycle();
            end
            MODE_RESTART: begin
                open_load();
                stream_bytes(7);
                prog_en = 1'b0;
                next_cycle();
                // These two strobes land in the edge detect and restart cycles
                prog_en   = 1'b1;
                prog_wr   = 1'b1;
                prog_data = 8'($urandom);
                next_cycle();
                next_cycle();
                prog_wr = 1'b0;
                stream_bytes(byte_counts[i]);
                close_load();
            end
            default: begin
                open_load();
                stream_bytes(byte_counts[i]);
                close_load();
            end
        endcase
        read_back();
        if (prog_full !== exp_full[i]) begin
            tb_errors++;
            $display("FAIL %s prog_full expected %0b actual %0b",
                     test_names[i], exp_full[i], prog_full);
        end
        if (chk.err_count + tb_errors == err_start) begin
            $display("test %s: ok", test_names[i]);
        end else begin
            $display("test %s: %0d errors", test_names[i],
                     chk.err_count + tb_errors - err_start);
        end
    endtask

    // Budget of four cycles per byte and per readback, plus setup margin
    initial begin
        int budget;
        budget = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            budget += byte_counts[i] + DEPTH;
        end
        budget = budget * 4 + 200;
        repeat (budget) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", budget);
        $display("Verification failed");
        $finish;
    end

    initial begin
        int unsigned seed_ret;
        int          total;
        seed_ret  = $urandom(32'hf553_c60d);
        rst_n     = 1'b0;
        prog_en   = 1'b0;
        prog_wr   = 1'b0;
        prog_data = 8'd0;
        iaddr     = '0;
        tb_errors = 0;
        repeat (2) @(posedge clk);
        #10;
        rst_n = 1'b1;
        next_cycle();
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(i);
        end
        total = chk.err_count + tb_errors;
        $display("Tests %0d, checks %0d, errors %0d", NUM_TESTS, chk.check_count, total);
        if (total == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
